// File: hdl/cop_mp_pkg.sv
package cop_mp_pkg;

    // Register file geometry
    localparam int CPR_COUNT  = 16;
    localparam int CPR_ADDR_W = 4;

    // Issue queue geometry
    localparam int ISSUE_DEPTH = 4;
    localparam int ISSUE_PTR_W = 2;

    // Bit 6 set means the amount is 64 or more, so the shift gives zero
    localparam int SHAMT_W = 7;

    typedef enum logic [3:0] {
        EQU  = 4'd0,
        LTU  = 4'd1,
        GTU  = 4'd2,
        ADD3 = 4'd3,
        ADD2 = 4'd4,
        SUB3 = 4'd5,
        SUB2 = 4'd6,
        SLLI = 4'd7,
        SLL  = 4'd8,
        SRLI = 4'd9,
        SRL  = 4'd10,
        ACC1 = 4'd12,
        MAC  = 4'd13
    } mp_subclass_e;   // 11, 14 and 15 are illegal

    // One decoded MP operation as held in the issue queue
    typedef struct packed {
        mp_subclass_e            subclass;
        logic [CPR_ADDR_W-2:0]   crd_pair;   // Writes 2k and 2k+1
        logic [CPR_ADDR_W-1:0]   crs1;
        logic [CPR_ADDR_W-1:0]   crs2;
        logic [CPR_ADDR_W-1:0]   crs3;
        logic [SHAMT_W-1:0]      shamt;      // Immediate shifts only
        logic                    chain_eq;   // CPU rs1 non-zero
    } mp_instr_t;

    // A single CPR write from the ALU
    typedef struct packed {
        logic [CPR_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } cpr_wb_t;

endpackage

// File: hdl/cop_cpr.sv
module cop_cpr import cop_mp_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic [CPR_ADDR_W-1:0] rd_addr1,
    input  logic [CPR_ADDR_W-1:0] rd_addr2,
    input  logic [CPR_ADDR_W-1:0] rd_addr3,
    input  logic                  wb_en,
    input  cpr_wb_t               wb,
    input  logic                  load_en,
    input  logic [CPR_ADDR_W-1:0] load_addr,
    input  logic [31:0]           load_data,
    output logic [31:0]           rd_data1,
    output logic [31:0]           rd_data2,
    output logic [31:0]           rd_data3
);

    logic [31:0] regs [CPR_COUNT];

    // Combinational reads
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];
    assign rd_data3 = regs[rd_addr3];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < CPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (load_en) regs[load_addr] <= load_data;
            // Later assignment, so the ALU wins a same-address clash
            if (wb_en) regs[wb.addr] <= wb.data;
        end
    end

endmodule

// File: hdl/cop_mp_decode.sv
module cop_mp_decode import cop_mp_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  instr_valid,
    input  logic [3:0]            instr_subclass,
    input  logic [CPR_ADDR_W-1:0] instr_crd,
    input  logic [CPR_ADDR_W-1:0] instr_crs1,
    input  logic [CPR_ADDR_W-1:0] instr_crs2,
    input  logic [CPR_ADDR_W-1:0] instr_crs3,
    input  logic [3:0]            instr_imm,
    input  logic [31:0]           gpr_rs1,
    output logic                  push,
    output mp_instr_t             push_item,
    output logic                  illegal
);

    mp_subclass_e sc;
    logic         legal;
    mp_instr_t    dec;

    assign sc = mp_subclass_e'(instr_subclass);

    // Subclass check
    always_comb begin
        case (sc)
            EQU, LTU, GTU,
            ADD3, ADD2, SUB3, SUB2,
            SLLI, SLL, SRLI, SRL,
            ACC1, MAC: legal = 1'b1;
            default:   legal = 1'b0;
        endcase
    end

    always_comb begin
        dec.subclass = sc;
        dec.crd_pair = instr_crd[CPR_ADDR_W-1:1];
        dec.crs1     = instr_crs1;
        dec.crs2     = instr_crs2;
        dec.crs3     = instr_crs3;
        dec.shamt    = '0;            // SLL/SRL take the amount from crs3
        dec.chain_eq = |gpr_rs1;
        case (sc)
            ACC1: begin
                // Accumulator is the destination pair itself
                dec.crs2 = {instr_crd[CPR_ADDR_W-1:1], 1'b1};
                dec.crs3 = {instr_crd[CPR_ADDR_W-1:1], 1'b0};
            end
            SLLI, SRLI: dec.shamt = {3'b000, instr_imm};
            default: ;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            push    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            push    <= instr_valid && legal;
            illegal <= instr_valid && !legal;   // Same slot as a push would be
        end
    end

    always_ff @(posedge g_clk) begin
        if (instr_valid) push_item <= dec;
    end

endmodule

// File: hdl/cop_mp_issue_queue.sv
module cop_mp_issue_queue import cop_mp_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      push,
    input  mp_instr_t push_item,
    input  logic      pop,
    output mp_instr_t head,
    output logic      not_empty,
    output logic      full
);

    mp_instr_t              mem [ISSUE_DEPTH];
    logic [ISSUE_PTR_W-1:0] wr_ptr;
    logic [ISSUE_PTR_W-1:0] rd_ptr;
    logic [ISSUE_PTR_W:0]   count;   // One extra bit to tell full from empty

    assign head      = mem[rd_ptr];
    assign not_empty = count != '0;
    assign full      = count == (ISSUE_PTR_W + 1)'(ISSUE_DEPTH);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // Both or neither leave the level alone
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (push) mem[wr_ptr] <= push_item;
    end

    // CPU side must watch queue_full before issuing
    a_no_push_full: assert property (
        @(posedge g_clk) disable iff (!g_resetn) push |-> !full
    ) else $error("issue queue push while full");

    // ALU only pops an entry it has been working on
    a_no_pop_empty: assert property (
        @(posedge g_clk) disable iff (!g_resetn) pop |-> not_empty
    ) else $error("issue queue pop while empty");

endmodule

// File: hdl/cop_mp_malu.sv
module cop_mp_malu import cop_mp_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  mp_instr_t             head,
    input  logic                  not_empty,
    input  logic [31:0]           rd_data1,
    input  logic [31:0]           rd_data2,
    input  logic [31:0]           rd_data3,
    output logic                  pop,
    output logic [CPR_ADDR_W-1:0] rd_addr1,
    output logic [CPR_ADDR_W-1:0] rd_addr2,
    output logic [CPR_ADDR_W-1:0] rd_addr3,
    output logic                  wb_en,
    output cpr_wb_t               wb,
    output logic                  active
);

    logic [1:0]         step;
    logic               s0, s1, s2;
    logic               is_cmp, is_two, is_three, is_shift;
    logic               is_shift_reg, is_right, is_acc1, is_mac, do_sub;
    logic               last, wb_hi;
    logic [63:0]        tmp;
    logic [63:0]        add_lhs, add_rhs, result_add;
    logic [63:0]        result_mul;
    logic [63:0]        result_shf;
    logic [SHAMT_W-1:0] shamt;
    logic               cmp_eq, cmp_lt, cmp_res;
    logic [31:0]        wdata;

    assign rd_addr1 = head.crs1;
    assign rd_addr2 = head.crs2;
    assign rd_addr3 = head.crs3;

    // Operation classes
    always_comb begin
        is_cmp       = 1'b0;
        is_two       = 1'b0;
        is_three     = 1'b0;
        is_shift     = 1'b0;
        is_shift_reg = 1'b0;
        is_right     = 1'b0;
        is_acc1      = 1'b0;
        is_mac       = 1'b0;
        do_sub       = 1'b0;
        case (head.subclass)
            EQU, LTU, GTU: is_cmp = 1'b1;
            ADD2:          is_two = 1'b1;
            SUB2: begin
                is_two = 1'b1;
                do_sub = 1'b1;
            end
            ACC1: begin
                is_two  = 1'b1;
                is_acc1 = 1'b1;
            end
            SLLI, SLL, SRLI, SRL: begin
                is_two       = 1'b1;
                is_shift     = 1'b1;
                is_right     = head.subclass inside {SRLI, SRL};
                is_shift_reg = head.subclass inside {SLL, SRL};
            end
            ADD3:          is_three = 1'b1;
            SUB3: begin
                is_three = 1'b1;
                do_sub   = 1'b1;
            end
            MAC: begin
                is_three = 1'b1;
                is_mac   = 1'b1;
            end
            default: ;
        endcase
    end

    assign s0 = not_empty && step == 2'd0;
    assign s1 = not_empty && step == 2'd1;
    assign s2 = not_empty && step == 2'd2;

    assign last   = (s0 && is_cmp) || (s1 && is_two) || (s2 && is_three);
    assign pop    = last;
    assign wb_hi  = (s1 && is_two) || (s2 && is_three);   // Upper word from tmp
    assign wb_en  = (s0 && !is_three) || s1 || s2;
    assign active = step != 2'd0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn)      step <= 2'd0;
        else if (last)      step <= 2'd0;   // Next head starts straight away
        else if (not_empty) step <= step + 2'd1;
    end

    // Shared adder, rs operands on step 0 then tmp plus rs3
    assign add_lhs    = (step == 2'd0) ? {32'b0, rd_data1} : tmp;
    assign add_rhs    = (step != 2'd0) ? {32'b0, rd_data3} :
                        is_acc1        ? {rd_data2, rd_data3} :
                                         {32'b0, rd_data2};
    assign result_add = do_sub ? add_lhs - add_rhs : add_lhs + add_rhs;

    assign result_mul = rd_data1 * rd_data2;

    // Pair shifter on {rs1, rs2}
    assign shamt      = is_shift_reg ? {|rd_data3[31:6], rd_data3[5:0]} : head.shamt;
    assign result_shf = shamt[SHAMT_W-1] ? 64'b0 :
                        is_right         ? {rd_data1, rd_data2} >> shamt[5:0] :
                                           {rd_data1, rd_data2} << shamt[5:0];

    // Chained compare of rs2 against rs3
    assign cmp_eq = rd_data2 == rd_data3;
    assign cmp_lt = rd_data2 < rd_data3;

    always_comb begin
        case (head.subclass)
            LTU:     cmp_res = (cmp_eq && head.chain_eq) || cmp_lt;
            GTU:     cmp_res = (cmp_eq && head.chain_eq) || !(cmp_lt || cmp_eq);
            default: cmp_res = cmp_eq && head.chain_eq;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (s0 && is_mac)
            tmp <= result_mul;
        else if (s0 && is_shift)
            tmp <= result_shf;
        else if ((s0 && !is_cmp) || (s1 && is_three))
            tmp <= result_add;
    end

    always_comb begin
        if (wb_hi)         wdata = tmp[63:32];
        else if (is_cmp)   wdata = {31'b0, cmp_res};
        else if (is_shift) wdata = result_shf[31:0];
        else               wdata = result_add[31:0];   // Low word, step 0 or 1
    end

    assign wb.addr = {head.crd_pair, wb_hi};
    assign wb.data = wdata;

    // An unhandled head subclass would never reach its last step
    a_head_known: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        not_empty |-> (is_cmp || is_two || is_three)
    ) else $error("ALU head holds an unhandled subclass");

    // Queue must hold the head steady until it is popped
    a_head_stable: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (step != 2'd0) |-> (not_empty && $stable(head))
    ) else $error("head changed during a multi-step operation");

endmodule

// File: hdl/cop_mp_top.sv
module cop_mp_top import cop_mp_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  instr_valid,
    input  logic [3:0]            instr_subclass,
    input  logic [CPR_ADDR_W-1:0] instr_crd,
    input  logic [CPR_ADDR_W-1:0] instr_crs1,
    input  logic [CPR_ADDR_W-1:0] instr_crs2,
    input  logic [CPR_ADDR_W-1:0] instr_crs3,
    input  logic [3:0]            instr_imm,
    input  logic [31:0]           gpr_rs1,
    input  logic                  load_en,
    input  logic [CPR_ADDR_W-1:0] load_addr,
    input  logic [31:0]           load_data,
    output logic                  queue_full,
    output logic                  busy,
    output logic                  illegal,
    output logic                  wb_valid,
    output logic [CPR_ADDR_W-1:0] wb_addr,
    output logic [31:0]           wb_data
);

    logic                  push, pop, not_empty, active, wb_en;
    mp_instr_t             push_item, head;
    cpr_wb_t               wb;
    logic [CPR_ADDR_W-1:0] rd_addr1, rd_addr2, rd_addr3;
    logic [31:0]           rd_data1, rd_data2, rd_data3;

    cop_mp_decode u_decode (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .instr_valid    (instr_valid),
        .instr_subclass (instr_subclass),
        .instr_crd      (instr_crd),
        .instr_crs1     (instr_crs1),
        .instr_crs2     (instr_crs2),
        .instr_crs3     (instr_crs3),
        .instr_imm      (instr_imm),
        .gpr_rs1        (gpr_rs1),
        .push           (push),
        .push_item      (push_item),
        .illegal        (illegal)
    );

    cop_mp_issue_queue u_queue (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (queue_full)
    );

    cop_mp_malu u_malu (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .head      (head),
        .not_empty (not_empty),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .rd_data3  (rd_data3),
        .pop       (pop),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .rd_addr3  (rd_addr3),
        .wb_en     (wb_en),
        .wb        (wb),
        .active    (active)
    );

    cop_cpr u_cpr (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .rd_addr3  (rd_addr3),
        .wb_en     (wb_en),
        .wb        (wb),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .rd_data3  (rd_data3)
    );

    // Decode slot, queued work or an operation mid-step
    assign busy     = push || not_empty || active;

    assign wb_valid = wb_en;
    assign wb_addr  = wb.addr;
    assign wb_data  = wb.data;

endmodule

// File: testbench/tb_cop_mp.sv
module tb_cop_mp import cop_mp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;   // Cycles allowed for any single wait
    localparam int RAND_OPS   = 40;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  instr_valid;
    logic [3:0]            instr_subclass;
    logic [CPR_ADDR_W-1:0] instr_crd, instr_crs1, instr_crs2, instr_crs3;
    logic [3:0]            instr_imm;
    logic [31:0]           gpr_rs1;
    logic                  load_en;
    logic [CPR_ADDR_W-1:0] load_addr;
    logic [31:0]           load_data;
    logic                  queue_full, busy, illegal, wb_valid;
    logic [CPR_ADDR_W-1:0] wb_addr;
    logic [31:0]           wb_data;

    cpr_wb_t     exp_q[$];    // Expected writebacks in issue order
    string       name_q[$];
    string       cur_name;
    int          errors;
    int          checks;
    int          illegal_seen;
    int          illegal_expected;
    logic        full_seen;
    logic        timed_out;
    logic [31:0] rng;

    cop_mp_top uut (.*);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Low word wraps, high word holds the carry or the borrow
    function automatic logic [63:0] addsub_ref(input logic sub, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] lo;
        logic [31:0] hi;
        if (sub) begin
            lo = a - b;
            hi = (a < b) ? 32'hffff_ffff : 32'h0;
        end else begin
            lo = a + b;
            hi = (lo < a) ? 32'd1 : 32'd0;
        end
        return {hi, lo};
    endfunction

    task automatic next_cycle();
        @(posedge g_clk);
        #2;
        instr_valid = 1'b0;   // Strobes last one cycle
        load_en     = 1'b0;
    endtask

    task automatic flag_bad_record(input string text);
        $display("Malformed trace record: %s", text);
        errors++;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy && !timed_out) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timeout: busy stayed high while waiting for %s", what);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic load_reg(input logic [3:0] addr, input logic [31:0] data);
        next_cycle();
        wait_idle("a register load");
        if (!timed_out) begin
            load_addr = addr;
            load_data = data;
            load_en   = 1'b1;
        end
    endtask

    task automatic issue_instr(input logic [3:0] sub, input logic [3:0] crd,
                               input logic [3:0] rs1, input logic [3:0] rs2,
                               input logic [3:0] rs3, input logic [3:0] imm,
                               input logic [31:0] gpr);
        int n;
        n = 0;
        next_cycle();
        while (queue_full && !timed_out) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timeout: queue_full stayed high before issuing %s", cur_name);
                timed_out = 1'b1;
                errors++;
            end
        end
        if (!timed_out) begin
            instr_subclass = sub;
            instr_crd      = crd;
            instr_crs1     = rs1;
            instr_crs2     = rs2;
            instr_crs3     = rs3;
            instr_imm      = imm;
            gpr_rs1        = gpr;
            instr_valid    = 1'b1;
        end
    endtask

    task automatic expect_wb(input logic [3:0] addr, input logic [31:0] data);
        cpr_wb_t w;
        w.addr = addr;
        w.data = data;
        exp_q.push_back(w);
        name_q.push_back(cur_name);
    endtask

    task automatic drain();
        next_cycle();
        wait_idle("the queue to drain");
        if (!timed_out && exp_q.size() != 0) begin
            $display("%0d expected writebacks never arrived, first one from %s",
                     exp_q.size(), name_q[0]);
            errors++;
            exp_q.delete();
            name_q.delete();
        end
    endtask

    // Mid-cycle, outputs are settled
    always @(negedge g_clk) begin
        cpr_wb_t want;
        string   name;
        if (g_resetn) begin
            if (queue_full) full_seen = 1'b1;
            if (illegal) illegal_seen++;
            if (wb_valid && exp_q.size() == 0) begin
                $display("Unexpected writeback to register %0d with data %08h",
                         wb_addr, wb_data);
                errors++;
            end else if (wb_valid) begin
                want = exp_q.pop_front();
                name = name_q.pop_front();
                checks++;
                if (wb_addr !== want.addr) begin
                    $display("Error %s: wb_addr expected %0d actual %0d",
                             name, want.addr, wb_addr);
                    errors++;
                end
                if (wb_data !== want.data) begin
                    $display("Error %s: wb_data expected %08h actual %08h",
                             name, want.data, wb_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        int          fd;
        int          code;
        string       line;
        string       tag;
        logic [31:0] v0, v1, v2, v3, v4, v5, v6;
        logic [63:0] res;
        logic [31:0] op_a, op_b;
        logic        use_sub;

        g_resetn         = 1'b0;
        instr_valid      = 1'b0;
        instr_subclass   = '0;
        instr_crd        = '0;
        instr_crs1       = '0;
        instr_crs2       = '0;
        instr_crs3       = '0;
        instr_imm        = '0;
        gpr_rs1          = '0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        errors           = 0;
        checks           = 0;
        illegal_seen     = 0;
        illegal_expected = 0;
        full_seen        = 1'b0;
        timed_out        = 1'b0;
        rng              = 32'h5396;
        cur_name         = "reset";

        repeat (2) @(posedge g_clk);
        #2;
        g_resetn = 1'b1;

        fd = $fopen("testbench/cop_mp_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/cop_mp_trace.txt");
            errors++;
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if ($sscanf(line, "%s", tag) != 1 || tag[0] == "#") continue;
            case (tag)
                "L": begin
                    code = $sscanf(line, "%s %h %h", tag, v0, v1);
                    if (code != 3) flag_bad_record(line);
                    else load_reg(v0[3:0], v1);
                end
                "I": begin
                    code = $sscanf(line, "%s %s %h %h %h %h %h %h %h", tag, cur_name,
                                   v0, v1, v2, v3, v4, v5, v6);
                    if (code != 9) flag_bad_record(line);
                    else issue_instr(v0[3:0], v1[3:0], v2[3:0], v3[3:0], v4[3:0],
                                     v5[3:0], v6);
                end
                "W": begin
                    code = $sscanf(line, "%s %h %h", tag, v0, v1);
                    if (code != 3) flag_bad_record(line);
                    else expect_wb(v0[3:0], v1);
                end
                "X":     illegal_expected++;
                "D":     drain();
                default: begin
                    $display("Unknown trace record type %s", tag);
                    errors++;
                end
            endcase
        end
        if (fd != 0) $fclose(fd);

        // Random ADD2/SUB2 on r1, r2 into pair r14/r15
        for (int i = 0; i < RAND_OPS && !timed_out; i++) begin
            rng     = xorshift32(rng);
            op_a    = rng;
            rng     = xorshift32(rng);
            op_b    = rng;
            rng     = xorshift32(rng);
            use_sub = rng[7];
            cur_name = $sformatf("%s_rand%0d", use_sub ? "sub2" : "add2", i);
            load_reg(4'd1, op_a);
            load_reg(4'd2, op_b);
            issue_instr(use_sub ? SUB2 : ADD2, 4'he, 4'd1, 4'd2, 4'd0, 4'd0, 32'd0);
            res = addsub_ref(use_sub, op_a, op_b);
            expect_wb(4'he, res[31:0]);
            expect_wb(4'hf, res[63:32]);
        end
        drain();

        if (illegal_seen != illegal_expected) begin
            $display("Error illegal_pulses: expected %0d actual %0d",
                     illegal_expected, illegal_seen);
            errors++;
        end
        if (!full_seen) begin
            $display("queue_full never went high during the back-to-back burst");
            errors++;
        end
        $display("Writeback checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/cop_mp_trace.txt
# L reg data | I name subclass crd crs1 crs2 crs3 imm gpr_rs1 | W wb_addr wb_data
# X illegal pulse expected | D drain until idle | all numbers hex
L 1 00000005
L 2 00000005
L 3 00000009
L 4 fffffff0
L 5 00000030
L 6 80000001
I equ_chain 0 8 0 1 2 0 1
W 8 00000001
I equ_nochain 0 8 0 1 2 0 0
W 8 00000000
I ltu_lt 1 8 0 1 3 0 0
W 8 00000001
I ltu_ge 1 8 0 3 1 0 1
W 8 00000000
I gtu_gt 2 8 0 3 1 0 0
W 8 00000001
I gtu_eq_chain 2 8 0 1 2 0 1
W 8 00000001
D
I add2_carry 4 a 4 5 0 0 0
W a 00000020
W b 00000001
I sub2_borrow 6 c 1 3 0 0 0
W c fffffffc
W d ffffffff
I acc1 c a 4 0 0 0 0
W a 00000010
W b 00000002
D
I add3 3 e 6 6 5 0 0
W e 00000032
W f 00000001
I sub3_borrow 5 e 1 2 3 0 0
W e fffffff7
W f ffffffff
I mac d e 4 6 5 0 0
W e 00000020
W f 7ffffff9
I add3_b2b 3 e 6 6 5 0 0
W e 00000032
W f 00000001
I mac_b2b d e 4 6 5 0 0
W e 00000020
W f 7ffffff9
D
I slli 7 8 6 3 0 4 0
W 8 00000090
W 9 00000010
I srli 9 8 6 3 0 8 0
W 8 01000000
W 9 00800000
I sll_reg 8 8 6 3 5 0 0
W 8 00000000
W 9 00090000
I srl_big a 8 6 3 4 0 0
W 8 00000000
W 9 00000000
I illegal_e e 8 0 0 0 0 0
X
D

// File: cop_mp_top.f
hdl/cop_mp_pkg.sv
hdl/cop_cpr.sv
hdl/cop_mp_decode.sv
hdl/cop_mp_issue_queue.sv
hdl/cop_mp_malu.sv
hdl/cop_mp_top.sv
testbench/tb_cop_mp.sv

// File: Bender.yml
package:
  name: cop_mp

sources:
  - hdl/cop_mp_pkg.sv
  - hdl/cop_cpr.sv
  - hdl/cop_mp_decode.sv
  - hdl/cop_mp_issue_queue.sv
  - hdl/cop_mp_malu.sv
  - hdl/cop_mp_top.sv
  - target: test
    files:
      - testbench/tb_cop_mp.sv
